// File: files.f
+incdir+hw
hw/trg_pkg.sv
hw/event_fifo.sv
hw/trg_regs.sv
hw/threshold_trigger.sv
hw/adc_trigger_top.sv
verif/adc_trigger_asserts.sv
verif/adc_trigger_tb.sv

// File: hw/adc_trigger_top.sv
`timescale 1ns/1ps
`include "trg_defines.svh"

module adc_trigger_top
    import trg_pkg::*;
(
    input  logic                          AXIS_ACLK,
    input  logic                          AXIS_ARESETN,
    input  tdata_t                        s_axis_tdata,
    input  reg_addr_t                     s_axi_awaddr,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,
    input  reg_data_t                     s_axi_wdata,
    input  logic [`TRG_AXI_STRB_BITS-1:0] s_axi_wstrb,
    input  logic                          s_axi_wvalid,
    output logic                          s_axi_wready,
    output logic                          s_axi_bvalid,
    output logic [1:0]                    s_axi_bresp,
    input  logic                          s_axi_bready,
    input  reg_addr_t                     s_axi_araddr,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    output reg_data_t                     s_axi_rdata,
    output logic                          s_axi_rvalid,
    output logic [1:0]                    s_axi_rresp,
    input  logic                          s_axi_rready,
    output logic                          trig_flag,
    output time_stamp_t                   trig_time_stamp
);

    // configuration from the register block
    logic        arm;
    adc_sample_t threshold;
    adc_sample_t baseline;
    win_len_t    post_len;
    win_len_t    acq_len;
    time_stamp_t current_time;

    // event path
    logic                          event_push;
    time_stamp_t                   event_time;
    logic                          fifo_pop;
    logic                          fifo_clear;
    time_stamp_t                   fifo_data;
    logic                          fifo_empty;
    logic [`TRG_FIFO_CNT_BITS-1:0] fifo_count;
    logic                          fifo_overflow;

    trg_regs trg_regs_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .awaddr        (s_axi_awaddr),
        .awvalid       (s_axi_awvalid),
        .awready       (s_axi_awready),
        .wdata         (s_axi_wdata),
        .wstrb         (s_axi_wstrb),
        .wvalid        (s_axi_wvalid),
        .wready        (s_axi_wready),
        .bvalid        (s_axi_bvalid),
        .bresp         (s_axi_bresp),
        .bready        (s_axi_bready),
        .araddr        (s_axi_araddr),
        .arvalid       (s_axi_arvalid),
        .arready       (s_axi_arready),
        .rdata         (s_axi_rdata),
        .rvalid        (s_axi_rvalid),
        .rresp         (s_axi_rresp),
        .rready        (s_axi_rready),
        .trig_flag     (trig_flag),
        .fifo_data     (fifo_data),
        .fifo_empty    (fifo_empty),
        .fifo_count    (fifo_count),
        .fifo_overflow (fifo_overflow),
        .arm           (arm),
        .threshold     (threshold),
        .baseline      (baseline),
        .post_len      (post_len),
        .acq_len       (acq_len),
        .current_time  (current_time),
        .fifo_pop      (fifo_pop),
        .fifo_clear    (fifo_clear)
    );

    threshold_trigger threshold_trigger_i (
        .AXIS_ACLK       (AXIS_ACLK),
        .AXIS_ARESETN    (AXIS_ARESETN),
        .s_axis_tdata    (s_axis_tdata),
        .arm             (arm),
        .threshold       (threshold),
        .baseline        (baseline),
        .post_len        (post_len),
        .acq_len         (acq_len),
        .current_time    (current_time),
        .trig_flag       (trig_flag),
        .trig_time_stamp (trig_time_stamp),
        .event_push      (event_push),
        .event_time      (event_time)
    );

    event_fifo event_fifo_i (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .push         (event_push),
        .push_data    (event_time),
        .pop          (fifo_pop),
        .clear        (fifo_clear),
        .pop_data     (fifo_data),
        .empty        (fifo_empty),
        .count        (fifo_count),
        .overflow     (fifo_overflow)
    );

endmodule

// File: hw/event_fifo.sv
`timescale 1ns/1ps
`include "trg_defines.svh"

module event_fifo
    import trg_pkg::*;
(
    input  logic                          AXIS_ACLK,
    input  logic                          AXIS_ARESETN,
    input  logic                          push,
    input  time_stamp_t                   push_data,
    input  logic                          pop,
    input  logic                          clear,
    output time_stamp_t                   pop_data,
    output logic                          empty,
    output logic [`TRG_FIFO_CNT_BITS-1:0] count,
    output logic                          overflow
);

    localparam logic [`TRG_FIFO_CNT_BITS-1:0] FULL_COUNT = `TRG_FIFO_DEPTH;

    time_stamp_t                   mem [`TRG_FIFO_DEPTH];
    logic [`TRG_FIFO_PTR_BITS-1:0] wr_ptr;
    logic [`TRG_FIFO_PTR_BITS-1:0] rd_ptr;
    logic                          full;
    logic                          do_push;
    logic                          do_pop;

    assign empty   = (count == '0);
    assign full    = (count == FULL_COUNT);
    assign do_pop  = pop && !empty;
    // a pop in the same cycle frees the slot
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (do_push && !clear)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN || clear)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until clear
            if (push && !do_push)
                overflow <= 1'b1;
        end
    end

    // head word is always visible
    assign pop_data = mem[rd_ptr];

endmodule

// File: hw/threshold_trigger.sv
`timescale 1ns/1ps
`include "trg_defines.svh"

module threshold_trigger
    import trg_pkg::*;
(
    input  logic        AXIS_ACLK,
    input  logic        AXIS_ARESETN,
    input  tdata_t      s_axis_tdata,
    input  logic        arm,
    input  adc_sample_t threshold,
    input  adc_sample_t baseline,
    input  win_len_t    post_len,
    input  win_len_t    acq_len,
    input  time_stamp_t current_time,
    output logic        trig_flag,
    output time_stamp_t trig_time_stamp,
    output logic        event_push,
    output time_stamp_t event_time
);

    logic [`TRG_LANES-1:0] lane_hit;
    logic                  hit;
    time_stamp_t           hit_time;
    trg_state_t            state;
    win_len_t              post_cnt;
    win_len_t              total_cnt;
    logic                  win_open;
    logic                  win_end;

    // samples below the baseline never count as a hit
    for (genvar i = 0; i < `TRG_LANES; i++)
    begin : g_lane
        adc_sample_t sample;
        adc_sample_t diff;

        assign sample      = s_axis_tdata[i*`TRG_LANE_BITS +: `TRG_ADC_BITS];
        assign diff        = sample - baseline;
        assign lane_hit[i] = (sample >= baseline) && (diff >= threshold);
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            hit <= 1'b0;
        else
            hit <= |lane_hit;
    end

    // time of the beat that produced hit
    always_ff @(posedge AXIS_ACLK)
    begin
        hit_time <= current_time;
    end

    assign win_open = (state == TRG_IDLE) && arm && hit;

    // total cap wins over a continuing hit
    assign win_end = (total_cnt >= acq_len) || (!hit && (post_cnt >= post_len));

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            state      <= TRG_IDLE;
            post_cnt   <= '0;
            total_cnt  <= '0;
            event_push <= 1'b0;
        end
        else
        begin
            event_push <= 1'b0;
            if (!arm)
            begin
                state <= TRG_IDLE;
            end
            else
            begin
                case (state)
                    TRG_IDLE:
                    begin
                        if (win_open)
                        begin
                            state      <= TRG_ACTIVE;
                            post_cnt   <= '0;
                            total_cnt  <= win_len_t'(1);
                            event_push <= 1'b1;
                        end
                    end
                    TRG_ACTIVE, TRG_POST:
                    begin
                        if (win_end)
                        begin
                            state <= TRG_REST;
                        end
                        else
                        begin
                            total_cnt <= total_cnt + 1'b1;
                            if (hit)
                            begin
                                // restart post count
                                state    <= TRG_ACTIVE;
                                post_cnt <= '0;
                            end
                            else
                            begin
                                state    <= TRG_POST;
                                post_cnt <= post_cnt + 1'b1;
                            end
                        end
                    end
                    TRG_REST: state <= TRG_IDLE;
                    default:  state <= TRG_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (win_open)
            trig_time_stamp <= hit_time;
    end

    assign trig_flag  = (state == TRG_ACTIVE) || (state == TRG_POST);
    assign event_time = trig_time_stamp;

endmodule

// File: hw/trg_defines.svh
`ifndef TRG_DEFINES_SVH
`define TRG_DEFINES_SVH

// sample layout of one converter beat
`define TRG_ADC_BITS       12
`define TRG_LANE_BITS      16
`define TRG_LANES          8
`define TRG_TDATA_BITS     128

`define TRG_TS_BITS        16
`define TRG_LEN_BITS       8

// event FIFO geometry
`define TRG_FIFO_DEPTH     8
`define TRG_FIFO_PTR_BITS  3
`define TRG_FIFO_CNT_BITS  4

`define TRG_AXI_ADDR_BITS  5
`define TRG_AXI_DATA_BITS  32
`define TRG_AXI_STRB_BITS  4

// register offsets
`define TRG_REG_CTRL       5'h00
`define TRG_REG_THRESH     5'h04
`define TRG_REG_BASE       5'h08
`define TRG_REG_POST       5'h0C
`define TRG_REG_ACQ        5'h10
`define TRG_REG_STATUS     5'h14
`define TRG_REG_EVENT      5'h18
`define TRG_REG_TIME       5'h1C

// reset values, threshold is about 10% of full scale
`define TRG_THRESH_RST     409
`define TRG_BASE_RST       0
`define TRG_POST_RST       38
`define TRG_ACQ_RST        100

`endif

// File: hw/trg_pkg.sv
`include "trg_defines.svh"

package trg_pkg;

    // one ADC sample, also used for baseline and threshold
    typedef logic [`TRG_ADC_BITS-1:0]      adc_sample_t;
    typedef logic [`TRG_TDATA_BITS-1:0]    tdata_t;
    typedef logic [`TRG_TS_BITS-1:0]       time_stamp_t;
    typedef logic [`TRG_LEN_BITS-1:0]      win_len_t;

    typedef logic [`TRG_AXI_DATA_BITS-1:0] reg_data_t;
    typedef logic [`TRG_AXI_ADDR_BITS-1:0] reg_addr_t;

    // window state machine
    typedef enum logic [1:0] {
        TRG_IDLE,
        TRG_ACTIVE,
        TRG_POST,
        TRG_REST
    } trg_state_t;

endpackage

// File: hw/trg_regs.sv
`timescale 1ns/1ps
`include "trg_defines.svh"

module trg_regs
    import trg_pkg::*;
(
    input  logic                          AXIS_ACLK,
    input  logic                          AXIS_ARESETN,
    input  reg_addr_t                     awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  reg_data_t                     wdata,
    input  logic [`TRG_AXI_STRB_BITS-1:0] wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic                          bvalid,
    output logic [1:0]                    bresp,
    input  logic                          bready,
    input  reg_addr_t                     araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output reg_data_t                     rdata,
    output logic                          rvalid,
    output logic [1:0]                    rresp,
    input  logic                          rready,
    input  logic                          trig_flag,
    input  time_stamp_t                   fifo_data,
    input  logic                          fifo_empty,
    input  logic [`TRG_FIFO_CNT_BITS-1:0] fifo_count,
    input  logic                          fifo_overflow,
    output logic                          arm,
    output adc_sample_t                   threshold,
    output adc_sample_t                   baseline,
    output win_len_t                      post_len,
    output win_len_t                      acq_len,
    output time_stamp_t                   current_time,
    output logic                          fifo_pop,
    output logic                          fifo_clear
);

    logic      wr_ready;
    logic      wr_en;
    logic      rd_en;
    reg_data_t wr_old;
    reg_data_t wr_new;
    reg_data_t rd_mux;

    // byte lanes not strobed keep their old contents
    function automatic reg_data_t merge_strb(
        input reg_data_t                     old_val,
        input reg_data_t                     new_val,
        input logic [`TRG_AXI_STRB_BITS-1:0] strb
    );
        reg_data_t res;
        res = old_val;
        for (int b = 0; b < `TRG_AXI_STRB_BITS; b++)
        begin
            if (strb[b])
                res[b*8 +: 8] = new_val[b*8 +: 8];
        end
        return res;
    endfunction

    assign awready = wr_ready;
    assign wready  = wr_ready;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    assign wr_en = wr_ready && awvalid && wvalid;
    assign rd_en = arready && arvalid;

    // address and data taken together, one write per response
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
        end
        else
        begin
            wr_ready <= !wr_ready && awvalid && wvalid && !bvalid;
            if (wr_en)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    // current contents of the addressed config register
    always_comb
    begin
        case (awaddr)
            `TRG_REG_THRESH: wr_old = reg_data_t'(threshold);
            `TRG_REG_BASE:   wr_old = reg_data_t'(baseline);
            `TRG_REG_POST:   wr_old = reg_data_t'(post_len);
            `TRG_REG_ACQ:    wr_old = reg_data_t'(acq_len);
            default:         wr_old = reg_data_t'(arm);
        endcase
    end

    assign wr_new = merge_strb(wr_old, wdata, wstrb);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            arm       <= 1'b0;
            threshold <= `TRG_THRESH_RST;
            baseline  <= `TRG_BASE_RST;
            post_len  <= `TRG_POST_RST;
            acq_len   <= `TRG_ACQ_RST;
        end
        else if (wr_en)
        begin
            case (awaddr)
                `TRG_REG_CTRL:   arm       <= wr_new[0];
                `TRG_REG_THRESH: threshold <= wr_new[`TRG_ADC_BITS-1:0];
                `TRG_REG_BASE:   baseline  <= wr_new[`TRG_ADC_BITS-1:0];
                `TRG_REG_POST:   post_len  <= wr_new[`TRG_LEN_BITS-1:0];
                `TRG_REG_ACQ:    acq_len   <= wr_new[`TRG_LEN_BITS-1:0];
                default:         arm       <= arm;
            endcase
        end
    end

    // write-one pulse, lasts the single accept cycle
    assign fifo_clear = wr_en && (awaddr == `TRG_REG_CTRL) && wstrb[0] && wdata[1];

    always_comb
    begin
        rd_mux = '0;
        case (araddr)
            `TRG_REG_CTRL:   rd_mux = reg_data_t'(arm);
            `TRG_REG_THRESH: rd_mux = reg_data_t'(threshold);
            `TRG_REG_BASE:   rd_mux = reg_data_t'(baseline);
            `TRG_REG_POST:   rd_mux = reg_data_t'(post_len);
            `TRG_REG_ACQ:    rd_mux = reg_data_t'(acq_len);
            `TRG_REG_STATUS:
            begin
                rd_mux[0]   = trig_flag;
                rd_mux[1]   = fifo_empty;
                rd_mux[2]   = fifo_overflow;
                rd_mux[7:4] = fifo_count;
            end
            `TRG_REG_EVENT:
            begin
                // bit 31 marks a valid event
                if (!fifo_empty)
                    rd_mux = {1'b1, 15'd0, fifo_data};
            end
            `TRG_REG_TIME:   rd_mux = reg_data_t'(current_time);
            default:         rd_mux = '0;
        endcase
    end

    assign fifo_pop = rd_en && (araddr == `TRG_REG_EVENT) && !fifo_empty;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            arready <= !arready && arvalid && !rvalid;
            if (rd_en)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (rd_en)
            rdata <= rd_mux;
    end

    // free-running time base, wraps
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            current_time <= '0;
        else
            current_time <= current_time + 1'b1;
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
rm -rf obj_dir run.log
verilator --binary --timing --assert -Wno-fatal -Ihw -f files.f \
    --top-module adc_trigger_tb -o sim
./obj_dir/sim +verilator+error+limit+1000 > run.log 2>&1
cat run.log
grep -q "TEST OK" run.log

// File: verif/adc_trigger_asserts.sv
`timescale 1ns/1ps

module adc_trigger_asserts (
    input logic        AXIS_ACLK,
    input logic        AXIS_ARESETN,
    input logic        arm,
    input logic        hit,
    input logic        trg_idle,
    input logic        trig_flag,
    input logic        event_push,
    input logic [3:0]  fifo_count,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata
);

    int fail_count = 0;

    // window opens one edge after a hit while idle and armed
    a_open: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (hit && trg_idle && arm) |=> (trig_flag && event_push))
        else
        begin
            $error("window did not open after hit");
            fail_count++;
        end

    a_push_on_rise: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        $rose(trig_flag) |-> event_push)
        else
        begin
            $error("flag rose without event push");
            fail_count++;
        end

    // one rest cycle after every close
    a_rest: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        $fell(trig_flag) |=> !trig_flag)
        else
        begin
            $error("window reopened without a rest cycle");
            fail_count++;
        end

    a_disarm: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        !arm |=> !trig_flag)
        else
        begin
            $error("flag high while disarmed");
            fail_count++;
        end

    a_fifo_bound: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        fifo_count <= 4'd8)
        else
        begin
            $error("fifo count beyond depth");
            fail_count++;
        end

    a_b_hold: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (bvalid && !bready) |=> bvalid)
        else
        begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    a_r_hold: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
        else
        begin
            $error("read response changed before rready");
            fail_count++;
        end

endmodule

// File: verif/adc_trigger_tb.sv
`timescale 1ns/1ps
`include "trg_defines.svh"

module adc_trigger_tb
    import trg_pkg::*;
;

    logic        AXIS_ACLK;
    logic        AXIS_ARESETN;
    tdata_t      s_axis_tdata;
    reg_addr_t   s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    reg_data_t   s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic        s_axi_bvalid;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bready;
    reg_addr_t   s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    reg_data_t   s_axi_rdata;
    logic        s_axi_rvalid;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rready;
    logic        trig_flag;
    time_stamp_t trig_time_stamp;

    int          errors = 0;
    int          seed = 32'h800436bf;
    time_stamp_t tb_time;
    logic        hit_on = 1'b0;
    int          hit_lane = 0;
    adc_sample_t hit_value = '0;
    // cycles that bready and rready stay low once a response is up
    int          resp_stall = 0;

    adc_trigger_top adc_trigger_top_i (.*);

    bind adc_trigger_top adc_trigger_asserts asserts_i (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .arm          (arm),
        .hit          (threshold_trigger_i.hit),
        .trg_idle     (threshold_trigger_i.state == TRG_IDLE),
        .trig_flag    (trig_flag),
        .event_push   (event_push),
        .fifo_count   (fifo_count),
        .bvalid       (s_axi_bvalid),
        .bready       (s_axi_bready),
        .rvalid       (s_axi_rvalid),
        .rready       (s_axi_rready),
        .rdata        (s_axi_rdata)
    );

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever #10 AXIS_ACLK = ~AXIS_ACLK;
    end

    // expected time base, one count per clock out of reset
    always @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            tb_time <= '0;
        else
            tb_time <= tb_time + 1'b1;
    end

    initial
    begin
        repeat (2000) @(posedge AXIS_ACLK);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // background lanes stay below baseline plus threshold
    task automatic drive_beat(input logic with_hit);
        tdata_t beat;
        beat = '0;
        for (int i = 0; i < `TRG_LANES; i++)
            beat[i*`TRG_LANE_BITS +: `TRG_ADC_BITS] = $random(seed) & 12'h0ff;
        if (with_hit)
            beat[hit_lane*`TRG_LANE_BITS +: `TRG_LANE_BITS] = {4'h0, hit_value};
        s_axis_tdata = beat;
    endtask

    task automatic tick();
        @(negedge AXIS_ACLK);
        drive_beat(hit_on);
    endtask

    task automatic check_value(input string name, input reg_data_t exp, input reg_data_t act);
        assert (exp == act)
        else
        begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic axi_write(input reg_addr_t addr, input reg_data_t data);
        tick();
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        s_axi_bready  = (resp_stall == 0);
        do tick(); while (!(s_axi_awready && s_axi_wready));
        tick();
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid)
            tick();
        check_value("write_bresp", 32'h0, {30'd0, s_axi_bresp});
        repeat (resp_stall) tick();
        s_axi_bready = 1'b1;
        tick();
    endtask

    task automatic axi_read(input reg_addr_t addr, output reg_data_t data,
                            output time_stamp_t snap);
        tick();
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        s_axi_rready  = (resp_stall == 0);
        do tick(); while (!s_axi_arready);
        snap = tb_time;
        tick();
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid)
            tick();
        repeat (resp_stall) tick();
        data = s_axi_rdata;
        check_value("read_rresp", 32'h0, {30'd0, s_axi_rresp});
        s_axi_rready = 1'b1;
        tick();
    endtask

    task automatic read_check(input string name, input reg_addr_t addr, input reg_data_t exp);
        reg_data_t   data;
        time_stamp_t snap;
        axi_read(addr, data, snap);
        check_value(name, exp, data);
    endtask

    // one hit beat, returns the expected time stamp
    task automatic fire(input int lane, input adc_sample_t value, output time_stamp_t ts);
        @(negedge AXIS_ACLK);
        hit_lane  = lane;
        hit_value = value;
        ts        = tb_time;
        drive_beat(1'b1);
    endtask

    task automatic measure_flag(output int cycles, output time_stamp_t rise_ts);
        int waited;
        cycles  = 0;
        waited  = 0;
        rise_ts = '0;
        forever
        begin
            @(negedge AXIS_ACLK);
            if (trig_flag)
            begin
                if (cycles == 0)
                    rise_ts = trig_time_stamp;
                cycles++;
            end
            else if (cycles > 0 || waited > 40)
            begin
                hit_on = 1'b0;
                drive_beat(1'b0);
                break;
            end
            else
                waited++;
            drive_beat(hit_on);
        end
    endtask

    initial
    begin
        time_stamp_t ts;
        time_stamp_t rise;
        time_stamp_t snap;
        time_stamp_t exp_q[$];
        reg_data_t   data;
        int          cycles;
        int          total;

        AXIS_ARESETN  = 1'b0;
        s_axis_tdata  = '0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 4'hf;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        repeat (3) @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        AXIS_ARESETN = 1'b1;

        // reset values and read back
        read_check("rst_thresh", `TRG_REG_THRESH, `TRG_THRESH_RST);
        read_check("rst_base", `TRG_REG_BASE, `TRG_BASE_RST);
        read_check("rst_post", `TRG_REG_POST, `TRG_POST_RST);
        read_check("rst_acq", `TRG_REG_ACQ, `TRG_ACQ_RST);
        read_check("rst_ctrl", `TRG_REG_CTRL, 32'h0);
        read_check("rst_status", `TRG_REG_STATUS, 32'h2);
        read_check("rst_event", `TRG_REG_EVENT, 32'h0);
        // responses held back by the master
        resp_stall = 2;
        axi_write(`TRG_REG_THRESH, 32'hffff_ffff);
        read_check("mask_thresh", `TRG_REG_THRESH, 32'hfff);
        resp_stall = 0;
        axi_write(`TRG_REG_POST, 32'h0000_01ff);
        read_check("mask_post", `TRG_REG_POST, 32'hff);
        read_check("unknown_addr", 5'h03, 32'h0);
        axi_read(`TRG_REG_TIME, data, snap);
        check_value("time_reg", {16'h0, snap}, data);

        axi_write(`TRG_REG_THRESH, 32'd300);
        axi_write(`TRG_REG_BASE, 32'd100);
        axi_write(`TRG_REG_POST, 32'd5);
        axi_write(`TRG_REG_ACQ, 32'd20);
        axi_write(`TRG_REG_CTRL, 32'h1);

        // compare at the boundary and below the baseline
        fire(3, 12'd400, ts);
        measure_flag(cycles, rise);
        check_value("edge_window_len", 32'd6, cycles);
        check_value("edge_trig_ts", {16'h0, ts}, {16'h0, rise});
        read_check("edge_event", `TRG_REG_EVENT, {1'b1, 15'd0, ts});
        fire(6, 12'd399, ts);
        measure_flag(cycles, rise);
        check_value("below_thresh", 32'd0, cycles);
        fire(0, 12'd50, ts);
        measure_flag(cycles, rise);
        check_value("below_base", 32'd0, cycles);
        read_check("compare_status", `TRG_REG_STATUS, 32'h2);

        // continuous hits cut at acq_len
        fire(5, 12'd900, ts);
        hit_on = 1'b1;
        measure_flag(cycles, rise);
        check_value("acq_cap_len", 32'd20, cycles);
        read_check("acq_event", `TRG_REG_EVENT, {1'b1, 15'd0, ts});

        // event order
        for (int n = 0; n < 3; n++)
        begin
            fire(n + 1, 12'd500 + n, ts);
            exp_q.push_back(ts);
            measure_flag(cycles, rise);
            check_value("order_trig_ts", {16'h0, ts}, {16'h0, rise});
        end
        while (exp_q.size() > 0)
            read_check("order_event", `TRG_REG_EVENT, {1'b1, 15'd0, exp_q.pop_front()});
        read_check("empty_event", `TRG_REG_EVENT, 32'h0);

        // overflow and clear
        for (int n = 0; n < 9; n++)
        begin
            fire(n % 8, 12'd700, ts);
            measure_flag(cycles, rise);
        end
        read_check("overflow_status", `TRG_REG_STATUS, 32'h84);
        axi_write(`TRG_REG_CTRL, 32'h3);
        read_check("clear_status", `TRG_REG_STATUS, 32'h2);

        // disarmed and disarm mid-window
        axi_write(`TRG_REG_CTRL, 32'h0);
        fire(2, 12'd800, ts);
        measure_flag(cycles, rise);
        check_value("disarmed_flag", 32'd0, cycles);
        read_check("disarmed_status", `TRG_REG_STATUS, 32'h2);
        axi_write(`TRG_REG_POST, 32'd50);
        axi_write(`TRG_REG_CTRL, 32'h1);
        fire(4, 12'd800, ts);
        do tick(); while (!trig_flag);
        axi_write(`TRG_REG_CTRL, 32'h0);
        check_value("disarm_drop", 32'd0, {31'd0, trig_flag});
        repeat (5) tick();
        // one event from the cut window stays queued
        read_check("disarm_status", `TRG_REG_STATUS, 32'h10);

        repeat (3) tick();
        total = errors + adc_trigger_top_i.asserts_i.fail_count;
        $display("errors: %0d checks, %0d assertions",
                 errors, adc_trigger_top_i.asserts_i.fail_count);
        if (total == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
